// ==== Makefile ====
# Verilator build and run of the rv_id_ex testbench

TOP := tb_rv_id_ex
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f rv_id_ex.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f rv_id_ex.f --top-module $(TOP)
	verilator --lint-only -Wall -f rv_id_ex.f --top-module rv_id_ex_top

clean:
	rm -rf obj_dir $(LOG)

// ==== include/rv_id_ex_cfg.svh ====
/* rv_id_ex configuration
   word width, register file geometry and RV32I instruction field positions */
`ifndef RV_ID_EX_CFG_SVH
`define RV_ID_EX_CFG_SVH

// --------------------------------------------------
// machine word and register file
`define XLEN     32       // data and pc width
`define REG_CNT  32       // architectural registers
`define REG_AW   5        // register address width

// --------------------------------------------------
// instruction fields
`define INSN_OP  6:0      // major opcode
`define INSN_RD  11:7     // destination
`define INSN_F3  14:12    // funct3
`define INSN_RS1 19:15    // source 1
`define INSN_RS2 24:20    // source 2 or shamt
`define INSN_F7  31:25    // funct7

`endif

// ==== logic/rv_decode_stage.sv ====
/* decode stage
   IF/ID register, RV32I decode with operand forwarding, ID/EX register */
`timescale 1ns/1ns
`default_nettype none
`include "rv_id_ex_cfg.svh"

module rv_decode_stage (
	input  wire                        clk_i,
	input  wire                        rst_n_i,
	input  wire                        fetch_vld_i,
	input  rv_id_ex_pkg::fetch_pkt_t   fetch_i,
	output logic [`REG_AW-1:0]         rs1_addr_o,
	output logic [`REG_AW-1:0]         rs2_addr_o,
	input  wire  [`XLEN-1:0]           rs1_data_i,
	input  wire  [`XLEN-1:0]           rs2_data_i,
	input  rv_id_ex_pkg::wb_pkt_t      ex_fwd_i,
	input  wire                        ex_fwd_vld_i,
	output logic                       dec_vld_o,
	output rv_id_ex_pkg::dec_pkt_t     dec_o,
	output logic                       illegal_vld_o
);
	import rv_id_ex_pkg::*;

	localparam logic [6:0] F7_ALT = 7'b0100000;   // sub / sra

	logic               if_vld;
	fetch_pkt_t         if_q;
	opcode_e            opcode;
	logic [`REG_AW-1:0] rd;
	logic [2:0]         f3;
	logic [6:0]         f7;
	logic [`XLEN-1:0]   imm_i, imm_sh, imm_u, imm_b, imm_j;
	logic [`XLEN-1:0]   rs1_val, rs2_val;
	logic               is_op, alt, chk_f7;
	logic               wr_rd, illegal;
	dec_pkt_t           dec_d;

	// --------------------------------------------------
	// IF/ID register
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			if_vld <= 1'b0;
		else
			if_vld <= fetch_vld_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (fetch_vld_i)
			if_q <= fetch_i;
	end

	// --------------------------------------------------
	// fields and immediates
	assign opcode     = opcode_e'(if_q.insn[`INSN_OP]);
	assign rd         = if_q.insn[`INSN_RD];
	assign f3         = if_q.insn[`INSN_F3];
	assign f7         = if_q.insn[`INSN_F7];
	assign rs1_addr_o = if_q.insn[`INSN_RS1];
	assign rs2_addr_o = if_q.insn[`INSN_RS2];

	assign imm_i  = {{20{if_q.insn[31]}}, if_q.insn[31:20]};
	assign imm_sh = {27'd0, if_q.insn[`INSN_RS2]};                // shamt
	assign imm_u  = {if_q.insn[31:12], 12'd0};
	assign imm_b  = {{20{if_q.insn[31]}}, if_q.insn[7], if_q.insn[30:25],
		if_q.insn[11:8], 1'b0};
	assign imm_j  = {{12{if_q.insn[31]}}, if_q.insn[19:12], if_q.insn[20],
		if_q.insn[30:21], 1'b0};

	// result still in execute wins over the register file
	assign rs1_val = (ex_fwd_vld_i && ex_fwd_i.we && (ex_fwd_i.rd == rs1_addr_o)
		&& (rs1_addr_o != '0)) ? ex_fwd_i.data : rs1_data_i;
	assign rs2_val = (ex_fwd_vld_i && ex_fwd_i.we && (ex_fwd_i.rd == rs2_addr_o)
		&& (rs2_addr_o != '0)) ? ex_fwd_i.data : rs2_data_i;

	assign is_op  = (opcode == OPC_OP);
	assign alt    = (f7 == F7_ALT);
	assign chk_f7 = is_op || (f3[1:0] == 2'b01);   // register ops and shifts

	// --------------------------------------------------
	// instruction decode
	always_comb
	begin
		dec_d         = '0;
		dec_d.pc      = if_q.pc;
		dec_d.pc4     = if_q.pc + `XLEN'd4;
		dec_d.alu_op  = ALU_NOP;
		dec_d.cmp_op  = CMP_NOP;
		dec_d.alu_a   = rs1_val;
		dec_d.alu_b   = rs2_val;
		dec_d.cmp_a   = rs1_val;
		dec_d.cmp_b   = rs2_val;
		dec_d.imm     = imm_i;
		dec_d.res_sel = RES_ALU;
		dec_d.rd      = rd;
		wr_rd         = 1'b0;
		illegal       = 1'b0;
		case (opcode)
			OPC_OP_IMM,
			OPC_OP:
			begin
				wr_rd = 1'b1;
				if (!is_op)
				begin
					dec_d.alu_b = (f3[1:0] == 2'b01) ? imm_sh : imm_i;
					dec_d.cmp_b = imm_i;
				end
				if (chk_f7 && (f7 != 7'd0)
					&& !(alt && ((f3 == 3'b101) || (is_op && (f3 == 3'b000)))))
					illegal = 1'b1;
				case (f3)
					3'b000: dec_d.alu_op = (is_op && alt) ? ALU_SUB : ALU_ADD;
					3'b001: dec_d.alu_op = ALU_SLL;
					3'b010: dec_d.cmp_op = CMP_LT;
					3'b011: dec_d.cmp_op = CMP_LTU;
					3'b100: dec_d.alu_op = ALU_XOR;
					3'b101: dec_d.alu_op = alt ? ALU_SRA : ALU_SRL;
					3'b110: dec_d.alu_op = ALU_OR;
					default: dec_d.alu_op = ALU_AND;
				endcase
				if (f3[2:1] == 2'b01)
					dec_d.res_sel = RES_CMP;    // slt family
			end
			OPC_LUI:
			begin
				wr_rd         = 1'b1;
				dec_d.imm     = imm_u;
				dec_d.res_sel = RES_IMM;
			end
			OPC_AUIPC:
			begin
				wr_rd        = 1'b1;
				dec_d.alu_op = ALU_ADD;
				dec_d.alu_a  = if_q.pc;
				dec_d.alu_b  = imm_u;
				dec_d.imm    = imm_u;
			end
			OPC_BRANCH:
			begin
				dec_d.alu_op  = ALU_ADD;       // target pc + imm_b
				dec_d.alu_a   = if_q.pc;
				dec_d.alu_b   = imm_b;
				dec_d.imm     = imm_b;
				dec_d.br_flag = 1'b1;
				case (f3)
					3'b000: dec_d.cmp_op = CMP_EQ;
					3'b001: dec_d.cmp_op = CMP_NE;
					3'b100: dec_d.cmp_op = CMP_LT;
					3'b101: dec_d.cmp_op = CMP_GE;
					3'b110: dec_d.cmp_op = CMP_LTU;
					3'b111: dec_d.cmp_op = CMP_GEU;
					default: illegal = 1'b1;
				endcase
			end
			OPC_JAL:
			begin
				wr_rd         = 1'b1;
				dec_d.alu_op  = ALU_ADD;
				dec_d.alu_a   = if_q.pc;
				dec_d.alu_b   = imm_j;
				dec_d.imm     = imm_j;
				dec_d.res_sel = RES_PC4;
				dec_d.jump    = 1'b1;
			end
			OPC_JALR:
			begin
				wr_rd         = 1'b1;
				dec_d.alu_op  = ALU_ADD;      // rs1 + imm_i
				dec_d.alu_b   = imm_i;
				dec_d.res_sel = RES_PC4;
				dec_d.jump    = 1'b1;
				illegal       = (f3 != 3'b000);
			end
			default: illegal = 1'b1;          // loads, stores, fence, system
		endcase
		dec_d.we = wr_rd && (rd != '0);
	end

	// --------------------------------------------------
	// ID/EX register
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			dec_vld_o     <= 1'b0;
			illegal_vld_o <= 1'b0;
		end
		else
		begin
			dec_vld_o     <= if_vld && !illegal;    // bad encoding leaves a bubble
			illegal_vld_o <= if_vld && illegal;
		end
	end

	always_ff @(posedge clk_i)
	begin
		dec_o <= dec_d;
	end

endmodule

`default_nettype wire

// ==== logic/rv_execute.sv ====
/* execute stage
   ALU, comparator, branch resolution and the writeback / redirect registers */
`timescale 1ns/1ns
`default_nettype none
`include "rv_id_ex_cfg.svh"

module rv_execute (
	input  wire                          clk_i,
	input  wire                          rst_n_i,
	input  wire                          dec_vld_i,
	input  rv_id_ex_pkg::dec_pkt_t       dec_i,
	output rv_id_ex_pkg::wb_pkt_t        ex_fwd_o,
	output logic                         ex_fwd_vld_o,
	output logic                         wb_vld_o,
	output rv_id_ex_pkg::wb_pkt_t        wb_o,
	output logic                         redirect_vld_o,
	output rv_id_ex_pkg::redirect_pkt_t  redirect_o
);
	import rv_id_ex_pkg::*;

	logic [`XLEN-1:0] alu_y;
	logic             cmp_y;
	logic [`XLEN-1:0] res_y;
	logic [4:0]       shamt;
	logic             take;

	assign shamt = dec_i.alu_b[4:0];

	// --------------------------------------------------
	// ALU
	always_comb
	begin
		case (dec_i.alu_op)
			ALU_ADD: alu_y = dec_i.alu_a + dec_i.alu_b;
			ALU_SUB: alu_y = dec_i.alu_a - dec_i.alu_b;
			ALU_SLL: alu_y = dec_i.alu_a << shamt;
			ALU_SRL: alu_y = dec_i.alu_a >> shamt;
			ALU_SRA: alu_y = $signed(dec_i.alu_a) >>> shamt;
			ALU_XOR: alu_y = dec_i.alu_a ^ dec_i.alu_b;
			ALU_OR:  alu_y = dec_i.alu_a | dec_i.alu_b;
			ALU_AND: alu_y = dec_i.alu_a & dec_i.alu_b;
			default: alu_y = '0;
		endcase
	end

	// comparator
	always_comb
	begin
		case (dec_i.cmp_op)
			CMP_EQ:  cmp_y = (dec_i.cmp_a == dec_i.cmp_b);
			CMP_NE:  cmp_y = (dec_i.cmp_a != dec_i.cmp_b);
			CMP_LT:  cmp_y = ($signed(dec_i.cmp_a) < $signed(dec_i.cmp_b));
			CMP_GE:  cmp_y = ($signed(dec_i.cmp_a) >= $signed(dec_i.cmp_b));
			CMP_LTU: cmp_y = (dec_i.cmp_a < dec_i.cmp_b);
			CMP_GEU: cmp_y = (dec_i.cmp_a >= dec_i.cmp_b);
			default: cmp_y = 1'b0;
		endcase
	end

	// result select
	always_comb
	begin
		case (dec_i.res_sel)
			RES_CMP: res_y = {{(`XLEN-1){1'b0}}, cmp_y};
			RES_PC4: res_y = dec_i.pc4;        // link address
			RES_IMM: res_y = dec_i.imm;
			default: res_y = alu_y;
		endcase
	end

	assign ex_fwd_o     = '{rd: dec_i.rd, we: dec_i.we, data: res_y};
	assign ex_fwd_vld_o = dec_vld_i;

	// jumps always, branches only when the condition holds
	assign take = dec_vld_i && (dec_i.jump || (dec_i.br_flag && cmp_y));

	// --------------------------------------------------
	// writeback and redirect registers
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wb_vld_o       <= 1'b0;
			redirect_vld_o <= 1'b0;
		end
		else
		begin
			wb_vld_o       <= dec_vld_i;
			redirect_vld_o <= take;
		end
	end

	always_ff @(posedge clk_i)
	begin
		wb_o              <= ex_fwd_o;
		redirect_o.target <= {alu_y[`XLEN-1:1], 1'b0};   // jalr clears bit 0
	end

endmodule

`default_nettype wire

// ==== logic/rv_id_ex_pkg.sv ====
/* rv_id_ex shared types
   opcode and control enums plus the packets passed between pipeline stages */
`default_nettype none
`include "rv_id_ex_cfg.svh"

package rv_id_ex_pkg;

	// RV32I major opcodes handled by this core
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_XOR, ALU_OR, ALU_AND, ALU_NOP
	} alu_op_e;

	typedef enum logic [2:0] {
		CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU, CMP_NOP
	} cmp_op_e;

	typedef enum logic [1:0] {
		RES_ALU, RES_CMP, RES_PC4, RES_IMM    // writeback source
	} res_sel_e;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] insn;
	} fetch_pkt_t;

	typedef struct packed {
		logic [`XLEN-1:0]   pc;
		logic [`XLEN-1:0]   pc4;        // link value
		alu_op_e            alu_op;
		cmp_op_e            cmp_op;
		logic [`XLEN-1:0]   alu_a;
		logic [`XLEN-1:0]   alu_b;
		logic [`XLEN-1:0]   cmp_a;
		logic [`XLEN-1:0]   cmp_b;
		logic [`XLEN-1:0]   imm;
		res_sel_e           res_sel;
		logic               br_flag;    // conditional branch
		logic               jump;       // jal or jalr
		logic [`REG_AW-1:0] rd;
		logic               we;
	} dec_pkt_t;

	typedef struct packed {
		logic [`REG_AW-1:0] rd;
		logic               we;
		logic [`XLEN-1:0]   data;
	} wb_pkt_t;

	typedef struct packed {
		logic [`XLEN-1:0] target;
	} redirect_pkt_t;

endpackage

`default_nettype wire

// ==== logic/rv_id_ex_top.sv ====
/* rv_id_ex top level
   decode stage, register file and execute stage of the RV32I core */
`timescale 1ns/1ns
`default_nettype none
`include "rv_id_ex_cfg.svh"

module rv_id_ex_top (
	input  wire                          clk_i,
	input  wire                          rst_n_i,
	input  wire                          fetch_vld_i,
	input  rv_id_ex_pkg::fetch_pkt_t     fetch_i,
	output logic                         wb_vld_o,
	output rv_id_ex_pkg::wb_pkt_t        wb_o,
	output logic                         redirect_vld_o,
	output rv_id_ex_pkg::redirect_pkt_t  redirect_o,
	output logic                         illegal_vld_o
);
	import rv_id_ex_pkg::*;

	logic [`REG_AW-1:0] rs1_addr, rs2_addr;
	logic [`XLEN-1:0]   rs1_data, rs2_data;
	logic               dec_vld;
	dec_pkt_t           dec;
	wb_pkt_t            ex_fwd;
	logic               ex_fwd_vld;

	// --------------------------------------------------
	rv_decode_stage u_decode (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.fetch_vld_i   (fetch_vld_i),
		.fetch_i       (fetch_i),
		.rs1_addr_o    (rs1_addr),
		.rs2_addr_o    (rs2_addr),
		.rs1_data_i    (rs1_data),
		.rs2_data_i    (rs2_data),
		.ex_fwd_i      (ex_fwd),
		.ex_fwd_vld_i  (ex_fwd_vld),
		.dec_vld_o     (dec_vld),
		.dec_o         (dec),
		.illegal_vld_o (illegal_vld_o)
	);

	rv_regfile u_regfile (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.we_i       (wb_vld_o),       // written from the writeback register
		.wr_i       (wb_o),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	rv_execute u_execute (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.dec_vld_i      (dec_vld),
		.dec_i          (dec),
		.ex_fwd_o       (ex_fwd),
		.ex_fwd_vld_o   (ex_fwd_vld),
		.wb_vld_o       (wb_vld_o),
		.wb_o           (wb_o),
		.redirect_vld_o (redirect_vld_o),
		.redirect_o     (redirect_o)
	);

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
/* register file
   32 x 32-bit, two read ports, one write port, x0 reads zero */
`timescale 1ns/1ns
`default_nettype none
`include "rv_id_ex_cfg.svh"

module rv_regfile (
	input  wire                      clk_i,
	input  wire                      rst_n_i,
	input  wire  [`REG_AW-1:0]       rs1_addr_i,
	input  wire  [`REG_AW-1:0]       rs2_addr_i,
	input  wire                      we_i,
	input  rv_id_ex_pkg::wb_pkt_t    wr_i,
	output logic [`XLEN-1:0]         rs1_data_o,
	output logic [`XLEN-1:0]         rs2_data_o
);

	logic [`XLEN-1:0] regs [`REG_CNT];
	logic             wr_en;

	assign wr_en = we_i && wr_i.we && (wr_i.rd != '0);   // x0 never written

	// read port with write-to-read bypass
	function automatic logic [`XLEN-1:0] rd_port(input logic [`REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wr_en && (wr_i.rd == addr))
			return wr_i.data;
		else
			return regs[addr];
	endfunction

	assign rs1_data_o = rd_port(rs1_addr_i);
	assign rs2_data_o = rd_port(rs2_addr_i);

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[wr_i.rd] <= wr_i.data;
	end

endmodule

`default_nettype wire

// ==== rv_id_ex.f ====
+incdir+include
logic/rv_id_ex_pkg.sv
logic/rv_decode_stage.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_id_ex_top.sv
sim/tb_rv_id_ex.sv

// ==== sim/tb_rv_id_ex.sv ====
/* testbench for the rv_id_ex core
   random and directed RV32I streams checked against a register model */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_id_ex;
	import rv_id_ex_pkg::*;

	logic          clk;
	logic          rst_n;
	logic          fetch_vld;
	fetch_pkt_t    fetch;
	logic          wb_vld;
	wb_pkt_t       wb;
	logic          redirect_vld;
	redirect_pkt_t redirect;
	logic          illegal_vld;

	logic [31:0] ref_regs [32];       // architectural state per RV32I
	logic [31:0] pc;
	int          cyc = 0;
	int          err_cnt = 0;
	int          err_mark;
	int          test_cnt = 0;
	int          timeouts = 0;
	string       cur_test;

	wb_pkt_t     wb_exp_q [$];
	logic        wb_chk_q [$];        // rd and data are meaningful
	int          wb_cyc_q [$];
	logic [31:0] rdr_tgt_q [$];
	int          rdr_cyc_q [$];
	int          ill_cyc_q [$];

	rv_id_ex_top uut (
		.clk_i          (clk),
		.rst_n_i        (rst_n),
		.fetch_vld_i    (fetch_vld),
		.fetch_i        (fetch),
		.wb_vld_o       (wb_vld),
		.wb_o           (wb),
		.redirect_vld_o (redirect_vld),
		.redirect_o     (redirect),
		.illegal_vld_o  (illegal_vld)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// --------------------------------------------------
	// instruction encoders
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	// --------------------------------------------------
	// checking
	task automatic report_value(input string what, input logic [31:0] want,
		input logic [31:0] got);
		$display("FAIL %s %s expected %h actual %h", cur_test, what, want, got);
		err_cnt++;
	endtask

	task automatic report_text(input string msg);
		$display("ERROR in %s: %s", cur_test, msg);
		err_cnt++;
	endtask

	// outputs checked on the falling edge
	always @(negedge clk)
	begin
		if (wb_cyc_q.size() > 0 && wb_cyc_q[0] == cyc)
		begin
			assert (wb_vld) else report_text("writeback strobe missing");
			assert (wb.we == wb_exp_q[0].we)
				else report_value("wb.we", 32'(wb_exp_q[0].we), 32'(wb.we));
			if (wb_chk_q[0])
			begin
				assert (wb.rd == wb_exp_q[0].rd)
					else report_value("wb.rd", 32'(wb_exp_q[0].rd), 32'(wb.rd));
				assert (wb.data == wb_exp_q[0].data)
					else report_value("wb.data", wb_exp_q[0].data, wb.data);
			end
			void'(wb_exp_q.pop_front());
			void'(wb_chk_q.pop_front());
			void'(wb_cyc_q.pop_front());
		end
		else
			assert (!wb_vld) else report_text("writeback strobe without an instruction");
		if (rdr_cyc_q.size() > 0 && rdr_cyc_q[0] == cyc)
		begin
			assert (redirect_vld) else report_text("redirect strobe missing");
			assert (redirect.target == rdr_tgt_q[0])
				else report_value("redirect.target", rdr_tgt_q[0], redirect.target);
			void'(rdr_tgt_q.pop_front());
			void'(rdr_cyc_q.pop_front());
		end
		else
			assert (!redirect_vld) else report_text("redirect on a path that is not taken");
		if (ill_cyc_q.size() > 0 && ill_cyc_q[0] == cyc)
		begin
			assert (illegal_vld) else report_text("illegal strobe missing");
			void'(ill_cyc_q.pop_front());
		end
		else
			assert (!illegal_vld) else report_text("illegal strobe on a legal instruction");
	end

	// --------------------------------------------------
	// issue one instruction and queue what the model expects
	task automatic issue(input logic [31:0] insn);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [31:0] a, b, ii, iu, res, tgt;
		logic        wr, bad, take;
		wb_pkt_t     want;
		begin
			rd   = insn[11:7];
			f3   = insn[14:12];
			a    = ref_regs[insn[19:15]];
			b    = ref_regs[insn[24:20]];
			ii   = {{20{insn[31]}}, insn[31:20]};
			iu   = {insn[31:12], 12'd0};
			res  = '0;
			tgt  = '0;
			wr   = 1'b1;
			bad  = 1'b0;
			take = 1'b0;
			case (insn[6:0])
				7'h13, 7'h33:
				begin
					if (insn[6:0] == 7'h13)
						b = (f3[1:0] == 2'b01) ? {27'd0, insn[24:20]} : ii;
					case (f3)
						3'd0: res = (insn[5] && insn[30]) ? a - b : a + b;
						3'd1: res = a << b[4:0];
						3'd2: res = {31'd0, $signed(a) < $signed(b)};
						3'd3: res = {31'd0, a < b};
						3'd4: res = a ^ b;
						3'd5:
						begin
							if (insn[30])
								res = $signed(a) >>> b[4:0];
							else
								res = a >> b[4:0];
						end
						3'd6: res = a | b;
						default: res = a & b;
					endcase
				end
				7'h37: res = iu;                  // lui
				7'h17: res = pc + iu;             // auipc
				7'h6f:
				begin
					res  = pc + 32'd4;
					take = 1'b1;
					tgt  = pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20],
						insn[30:21], 1'b0};
				end
				7'h67:
				begin
					res  = pc + 32'd4;
					take = 1'b1;
					tgt  = (a + ii) & 32'hffff_fffe;
				end
				7'h63:
				begin
					wr  = 1'b0;
					tgt = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25],
						insn[11:8], 1'b0};
					case (f3)
						3'd0: take = (a == b);
						3'd1: take = (a != b);
						3'd4: take = ($signed(a) < $signed(b));
						3'd5: take = ($signed(a) >= $signed(b));
						3'd6: take = (a < b);
						3'd7: take = (a >= b);
						default: bad = 1'b1;
					endcase
				end
				default:
				begin
					bad = 1'b1;
					wr  = 1'b0;
				end
			endcase
			@(posedge clk);
			#1;
			fetch_vld = 1'b1;
			fetch     = '{pc: pc, insn: insn};
			if (bad)
				ill_cyc_q.push_back(cyc + 2);
			else
			begin
				want = '{rd: rd, we: wr && (rd != 5'd0), data: res};
				wb_exp_q.push_back(want);
				wb_chk_q.push_back(wr);
				wb_cyc_q.push_back(cyc + 3);     // two edges after the sampling edge
				if (want.we)
					ref_regs[rd] = res;
				if (take)
				begin
					rdr_tgt_q.push_back(tgt);
					rdr_cyc_q.push_back(cyc + 3);
				end
			end
			pc = pc + 32'd4;
		end
	endtask

	task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
		logic [31:0] up;
		begin
			up = v + 32'h800;                    // addi sign-extends the low part
			issue(enc_u(up[31:12], r, 7'h37));
			issue(enc_i(v[11:0], r, 3'd0, r, 7'h13));
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_mark = err_cnt;
	endtask

	task automatic end_test();
		int waited;
		begin
			@(posedge clk);
			#1;
			fetch_vld = 1'b0;
			waited = 0;
			while ((wb_cyc_q.size() + rdr_cyc_q.size() + ill_cyc_q.size()) != 0
				&& waited < 40)
			begin
				@(posedge clk);
				waited++;
			end
			if ((wb_cyc_q.size() + rdr_cyc_q.size() + ill_cyc_q.size()) != 0)
			begin
				$display("ERROR in %s: expected strobes never arrived", cur_test);
				timeouts++;
				wb_exp_q.delete();
				wb_chk_q.delete();
				wb_cyc_q.delete();
				rdr_tgt_q.delete();
				rdr_cyc_q.delete();
				ill_cyc_q.delete();
			end
			repeat (2) @(posedge clk);           // catch late stray strobes
			$display("test %s done, %0d errors", cur_test, err_cnt - err_mark);
			test_cnt++;
		end
	endtask

	// --------------------------------------------------
	// test sequence
	initial
	begin
		logic [4:0]  hist [3];
		logic [4:0]  rd, rs1, rs2, sh;
		logic [11:0] imm;
		logic [31:0] v;
		logic [31:0] pa [3];
		logic [31:0] pb [3];
		logic [2:0]  conds [6];

		void'($urandom(45962));
		rst_n     = 1'b0;
		fetch_vld = 1'b0;
		fetch     = '0;
		pc        = 32'h0000_1000;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;

		start_test("reset_quiet");
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		end_test();

		start_test("alu");
		for (int r = 1; r < 8; r++)
			load_reg(5'(r), $urandom());
		hist = '{5'd7, 5'd6, 5'd5};
		for (int k = 0; k < 80; k++)
		begin
			rd  = 5'($urandom_range(7, 1));
			rs1 = hist[$urandom_range(2, 0)];    // distance 1 to 3
			rs2 = hist[$urandom_range(2, 0)];
			imm = 12'($urandom());
			sh  = 5'($urandom());
			case ($urandom_range(14, 0))
				0: issue(enc_i(imm, rs1, 3'd0, rd, 7'h13));
				1: issue(enc_i(imm, rs1, 3'd4, rd, 7'h13));
				2: issue(enc_i(imm, rs1, 3'd6, rd, 7'h13));
				3: issue(enc_i(imm, rs1, 3'd7, rd, 7'h13));
				4: issue(enc_i({7'h00, sh}, rs1, 3'd1, rd, 7'h13));
				5: issue(enc_i({7'h00, sh}, rs1, 3'd5, rd, 7'h13));
				6: issue(enc_i({7'h20, sh}, rs1, 3'd5, rd, 7'h13));
				7: issue(enc_r(7'h00, rs2, rs1, 3'd0, rd));
				8: issue(enc_r(7'h20, rs2, rs1, 3'd0, rd));
				9: issue(enc_r(7'h00, rs2, rs1, 3'd1, rd));
				10: issue(enc_r(7'h00, rs2, rs1, 3'd5, rd));
				11: issue(enc_r(7'h20, rs2, rs1, 3'd5, rd));
				12: issue(enc_r(7'h00, rs2, rs1, 3'd4, rd));
				13: issue(enc_r(7'h00, rs2, rs1, 3'd6, rd));
				default: issue(enc_r(7'h00, rs2, rs1, 3'd7, rd));
			endcase
			hist[2] = hist[1];
			hist[1] = hist[0];
			hist[0] = rd;
		end
		end_test();

		start_test("compare_upper");
		for (int k = 0; k < 8; k++)
		begin
			v = $urandom();
			load_reg(5'd1, v);
			load_reg(5'd2, (k == 0) ? v : $urandom());    // one equal pair
			imm = 12'($urandom());
			issue(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3));    // slt
			issue(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd4));    // sltu
			issue(enc_i(imm, 5'd1, 3'd2, 5'd5, 7'h13));     // slti
			issue(enc_i(imm, 5'd1, 3'd3, 5'd6, 7'h13));     // sltiu
			issue(enc_u(20'($urandom()), 5'd7, 7'h37));
			issue(enc_u(20'($urandom()), 5'd8, 7'h17));
		end
		end_test();

		start_test("branch_jump");
		pa    = '{32'd5, 32'd5, 32'hffff_fffd};
		pb    = '{32'd5, 32'd7, 32'd4};
		conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (int p = 0; p < 3; p++)
		begin
			load_reg(5'd1, pa[p]);
			load_reg(5'd2, pb[p]);
			for (int c = 0; c < 6; c++)
				issue(enc_b(13'($urandom()) & 13'h1ffe, 5'd2, 5'd1, conds[c]));
		end
		issue(enc_j(21'($urandom()) & 21'h1ffffe, 5'd9));
		load_reg(5'd1, $urandom() | 32'd1);      // odd base for jalr
		issue(enc_i(12'($urandom()), 5'd1, 3'd0, 5'd10, 7'h67));
		issue(enc_r(7'h00, 5'd10, 5'd9, 3'd0, 5'd11));    // uses both link values
		end_test();

		start_test("x0_illegal");
		load_reg(5'd1, 32'h1234_5678);
		issue(enc_i(12'd5, 5'd1, 3'd0, 5'd0, 7'h13));     // write to x0
		issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd12));
		issue(enc_r(7'h00, 5'd1, 5'd0, 3'd6, 5'd13));
		issue(enc_i(12'd0, 5'd1, 3'd2, 5'd5, 7'h03));     // lw
		issue({7'd0, 5'd2, 5'd1, 3'd2, 5'd4, 7'h23});     // sw
		issue(enc_i(12'd0, 5'd1, 3'd0, 5'd6, 7'h7f));     // unknown opcode
		issue(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd14));
		end_test();

		$display("tests %0d, errors %0d, timeouts %0d", test_cnt, err_cnt, timeouts);
		if (err_cnt == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
